//--- all.f
hw/chiplet_types_pkg.sv
hw/chiplet_bus_pkg.sv
hw/flit_fifo.sv
hw/tile_router.sv
hw/tile_bus_regs.sv
hw/tile.sv
hw/tile_wrapper.sv
dv/tb_clock.sv
dv/tile_wrapper_assert.sv
dv/tile_wrapper_tb.sv

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // Released on a rising edge so the first active cycle is a full one.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/tile_wrapper_assert.sv
`timescale 1ns/1ps

module tile_wrapper_assert #(
    parameter int BUFFER_SIZE = 4
) (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           inject,
    input logic                           inject_ready,
    input chiplet_types_pkg::flit_t       inject_flit,
    input chiplet_types_pkg::link_fwd_t   link_out [chiplet_types_pkg::NUM_LINKS],
    input logic                           credit_in [chiplet_types_pkg::NUM_LINKS],
    input chiplet_types_pkg::credit_cnt_t credit_cnt [chiplet_types_pkg::NUM_LINKS]
);
    import chiplet_types_pkg::*;

    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
        int outstanding;

        // Flits sent on this link that the neighbor has not yet returned.
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                outstanding <= 0;
            end else begin
                outstanding <= outstanding + int'(link_out[l].valid) - int'(credit_in[l]);
            end
        end

        // A flit on the wire must have been paid for.
        a_valid_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
            link_out[l].valid |-> (outstanding < BUFFER_SIZE))
            else $error("link %0d sent a flit with zero credits", l);

        a_credit_bounded: assert property (@(posedge clk) disable iff (!rst_n)
            int'(credit_cnt[l]) <= BUFFER_SIZE)
            else $error("link %0d credit count above buffer size", l);
    end

    // A waiting injection keeps its flit until the router takes it.
    a_inject_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (inject && !inject_ready) |=> (inject && $stable(inject_flit)))
        else $error("inject flit changed while waiting for the router");

endmodule

//--- dv/tile_wrapper_tb.sv
`timescale 1ns/1ps

module tile_wrapper_tb;
    import chiplet_types_pkg::*;
    import chiplet_bus_pkg::*;

    localparam int BUFFER_SIZE = 4;
    localparam int STALL_LIMIT = 200;
    localparam int POLL_LIMIT  = 100;
    localparam int BURST_LEN   = 10;
    localparam int MAX_CYCLES  = 50000;

    typedef struct {
        string    name;
        node_id_t src;
        node_id_t dest;
        payload_t payload;
        strobe_t  strobe;
        payload_t expect_payload;
    } entry_t;

    logic     clk;
    logic     rst_n;
    bus_req_t bus_req [NUM_TILES];
    bus_rsp_t bus_rsp [NUM_TILES];
    entry_t   stim [$];
    string    test_name;
    int       test_errors;
    int       pass_count;
    int       fail_count;

    tb_clock #(
        .HALF_PERIOD (5),
        .RESET_CYCLES(8)
    ) i_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    tile_wrapper #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) i_tile_wrapper (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp)
    );

    bind tile_router tile_wrapper_assert #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) i_router_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .inject      (inject),
        .inject_ready(inject_ready),
        .inject_flit (inject_flit),
        .link_out    (link_out),
        .credit_in   (credit_in),
        .credit_cnt  (credit_cnt)
    );

    ////////////////////
    // Bookkeeping and compares.
    ////////////////////

    // Each strobe bit keeps or clears its whole byte lane.
    function automatic payload_t mask_bytes(input payload_t data, input strobe_t strobe);
        payload_t keep;
        keep = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
        return data & keep;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("ok   %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d errors)", test_name, test_errors);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Failure in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Error in %s: %s expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_node(input string what, input node_id_t exp, input node_id_t act);
        if (act !== exp) begin
            $display("Error in %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error in %s: %s expected %b, actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    ////////////////////
    // Bus access.
    ////////////////////

    // Response is sampled at the falling edge, the request retires on the next rising edge.
    task automatic bus_access(input int t, input logic write, input addr_t addr,
                              input data_t wdata, input strobe_t strobe,
                              output data_t rdata, output logic error);
        int waited;
        @(posedge clk);
        bus_req[t] <= '{wen: write, ren: !write, addr: addr, wdata: wdata, strobe: strobe};
        waited = 0;
        @(negedge clk);
        while (bus_rsp[t].request_stall && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (bus_rsp[t].request_stall) begin
            report_failure($sformatf("tile %0d bus access to %h stayed stalled", t, addr));
        end
        rdata = bus_rsp[t].rdata;
        error = bus_rsp[t].error;
        @(posedge clk);
        bus_req[t] <= '0;
    endtask

    task automatic bus_write(input int t, input addr_t addr, input data_t wdata,
                             input strobe_t strobe, output logic error);
        data_t unused;
        bus_access(t, 1'b1, addr, wdata, strobe, unused, error);
    endtask

    task automatic bus_read(input int t, input addr_t addr, output data_t rdata,
                            output logic error);
        bus_access(t, 1'b0, addr, '0, 4'hF, rdata, error);
    endtask

    task automatic wait_rx_count(input int t, input int target, output data_t status);
        logic err;
        int   polls;
        polls = 0;
        bus_read(t, REG_STATUS, status, err);
        while (int'(status[3:0]) < target && polls < POLL_LIMIT) begin
            bus_read(t, REG_STATUS, status, err);
            polls++;
        end
        if (int'(status[3:0]) < target) begin
            report_failure($sformatf("tile %0d fill count never reached %0d", t, target));
        end
    endtask

    ////////////////////
    // Tests.
    ////////////////////

    task automatic add_entry(input string name, input node_id_t src, input node_id_t dest,
                             input strobe_t strobe);
        entry_t e;
        e.name           = name;
        e.src            = src;
        e.dest           = dest;
        e.payload        = $urandom();
        e.strobe         = strobe;
        e.expect_payload = mask_bytes(e.payload, strobe);
        stim.push_back(e);
    endtask

    task automatic run_entry(input entry_t e);
        data_t status;
        data_t rdata;
        logic  err;
        start_test(e.name);
        bus_write(e.src, REG_TX_DEST, data_t'(e.dest), 4'h1, err);
        check_flag("tx_dest error", 1'b0, err);
        bus_write(e.src, REG_TX_DATA, e.payload, e.strobe, err);
        check_flag("tx_data error", 1'b0, err);
        wait_rx_count(e.dest, 1, status);
        check_data("fill count", 32'd1, data_t'(status[3:0]));
        check_node("src", e.src, status[5:4]);
        bus_read(e.dest, REG_RX_DATA, rdata, err);
        check_data("payload", e.expect_payload, rdata);
        check_flag("rx_data error", 1'b0, err);
        finish_test();
    endtask

    // More flits than one buffer holds, all read back after the sends.
    task automatic run_backpressure();
        payload_t sent [$];
        payload_t p;
        data_t    status;
        data_t    rdata;
        logic     err;
        start_test("backpressure_0_to_3");
        bus_write(0, REG_TX_DEST, 32'd3, 4'h1, err);
        for (int i = 0; i < BURST_LEN; i++) begin
            p = $urandom();
            sent.push_back(p);
            bus_write(0, REG_TX_DATA, p, 4'hF, err);
        end
        wait_rx_count(3, BUFFER_SIZE, status);
        check_data("capped fill count", data_t'(BUFFER_SIZE), data_t'(status[3:0]));
        for (int i = 0; i < BURST_LEN; i++) begin
            wait_rx_count(3, 1, status);
            check_node("src", 2'd0, status[5:4]);
            bus_read(3, REG_RX_DATA, rdata, err);
            check_data($sformatf("payload %0d", i), sent[i], rdata);
        end
        finish_test();
    endtask

    task automatic run_errors();
        data_t rdata;
        logic  err;
        start_test("bus_errors");
        bus_read(1, REG_RX_DATA, rdata, err);
        check_flag("empty rx read error", 1'b1, err);
        bus_read(1, 32'h10, rdata, err);
        check_flag("unmapped read error", 1'b1, err);
        bus_write(1, REG_STATUS, 32'h0, 4'hF, err);
        check_flag("status write error", 1'b1, err);
        bus_read(1, REG_STATUS, rdata, err);
        check_flag("status read error", 1'b0, err);
        bus_write(1, REG_TX_DEST, 32'd2, 4'h1, err);
        check_flag("tx_dest write error", 1'b0, err);
        finish_test();
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("tests failed");
        $finish;
    end

    initial begin
        int waited;
        void'($urandom(32'hee7a2aa3));
        for (int i = 0; i < NUM_TILES; i++) begin
            bus_req[i] = '0;
        end
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        test_name   = "reset";

        add_entry("edge_0_to_1", 2'd0, 2'd1, 4'hF);
        add_entry("edge_0_to_2", 2'd0, 2'd2, 4'hF);
        add_entry("edge_1_to_0", 2'd1, 2'd0, 4'hF);
        add_entry("edge_1_to_3", 2'd1, 2'd3, 4'hF);
        add_entry("edge_2_to_0", 2'd2, 2'd0, 4'hF);
        add_entry("edge_2_to_3", 2'd2, 2'd3, 4'hF);
        add_entry("edge_3_to_1", 2'd3, 2'd1, 4'hF);
        add_entry("edge_3_to_2", 2'd3, 2'd2, 4'hF);
        add_entry("diag_0_to_3", 2'd0, 2'd3, 4'hF);
        add_entry("diag_1_to_2", 2'd1, 2'd2, 4'hF);
        add_entry("self_3", 2'd3, 2'd3, 4'hF);
        add_entry("strobe_2_to_1", 2'd2, 2'd1, 4'b0101);
        add_entry("strobe_self_0", 2'd0, 2'd0, 4'b1000);

        waited = 0;
        while (rst_n !== 1'b1 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            fail_count++;
        end

        foreach (stim[i]) begin
            run_entry(stim[i]);
        end
        run_backpressure();
        run_errors();

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hw/chiplet_bus_pkg.sv
package chiplet_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strobe_t;

    typedef struct packed {
        logic    wen;
        logic    ren;
        addr_t   addr;
        data_t   wdata;
        strobe_t strobe;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  error;
        logic  request_stall;
    } bus_rsp_t;

    ////////////////////
    // Register map.
    ////////////////////

    localparam addr_t REG_TX_DEST = 32'h0000_0000;
    localparam addr_t REG_TX_DATA = 32'h0000_0004;
    localparam addr_t REG_RX_DATA = 32'h0000_0008;
    localparam addr_t REG_STATUS  = 32'h0000_000C;

endpackage

//--- hw/chiplet_types_pkg.sv
package chiplet_types_pkg;

    localparam int NUM_TILES = 4;
    localparam int NUM_LINKS = 2;

    // Tile number. Bit 0 is X, bit 1 is Y.
    typedef logic [1:0] node_id_t;

    typedef logic [31:0] payload_t;

    // Wide enough for buffer depths up to 15.
    typedef logic [3:0] credit_cnt_t;

    typedef struct packed {
        node_id_t dest;
        node_id_t src;
        payload_t payload;
    } flit_t;

    // Sender to receiver half of a link.
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_fwd_t;

endpackage

//--- hw/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  chiplet_types_pkg::flit_t       push_flit,
    input  logic                           pop,
    output chiplet_types_pkg::flit_t       head,
    output logic                           empty,
    output logic                           full,
    output chiplet_types_pkg::credit_cnt_t count
);
    import chiplet_types_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == credit_cnt_t'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

endmodule

//--- hw/tile.sv
`timescale 1ns/1ps

module tile #(
    parameter chiplet_types_pkg::node_id_t NODE_ID = '0,
    parameter int BUFFER_SIZE = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  chiplet_bus_pkg::bus_req_t    bus_req,
    output chiplet_bus_pkg::bus_rsp_t    bus_rsp,
    input  chiplet_types_pkg::link_fwd_t link_in [chiplet_types_pkg::NUM_LINKS],
    output logic                         credit_out [chiplet_types_pkg::NUM_LINKS],
    output chiplet_types_pkg::link_fwd_t link_out [chiplet_types_pkg::NUM_LINKS],
    input  logic                         credit_in [chiplet_types_pkg::NUM_LINKS]
);
    import chiplet_types_pkg::*;

    logic        inject;
    flit_t       inject_flit;
    logic        inject_ready;
    logic        rx_pop;
    flit_t       rx_head;
    credit_cnt_t rx_count;

    tile_bus_regs #(
        .NODE_ID(NODE_ID)
    ) i_bus_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .inject      (inject),
        .inject_flit (inject_flit),
        .inject_ready(inject_ready),
        .rx_pop      (rx_pop),
        .rx_head     (rx_head),
        .rx_count    (rx_count)
    );

    tile_router #(
        .NODE_ID    (NODE_ID),
        .BUFFER_SIZE(BUFFER_SIZE)
    ) i_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .inject      (inject),
        .inject_flit (inject_flit),
        .inject_ready(inject_ready),
        .link_in     (link_in),
        .credit_out  (credit_out),
        .link_out    (link_out),
        .credit_in   (credit_in),
        .rx_pop      (rx_pop),
        .rx_head     (rx_head),
        .rx_count    (rx_count)
    );

endmodule

//--- hw/tile_bus_regs.sv
`timescale 1ns/1ps

module tile_bus_regs #(
    parameter chiplet_types_pkg::node_id_t NODE_ID = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  chiplet_bus_pkg::bus_req_t      bus_req,
    output chiplet_bus_pkg::bus_rsp_t      bus_rsp,
    output logic                           inject,
    output chiplet_types_pkg::flit_t       inject_flit,
    input  logic                           inject_ready,
    output logic                           rx_pop,
    input  chiplet_types_pkg::flit_t       rx_head,
    input  chiplet_types_pkg::credit_cnt_t rx_count
);
    import chiplet_types_pkg::*;
    import chiplet_bus_pkg::*;

    node_id_t tx_dest;
    payload_t tx_payload;
    logic     wr;
    logic     rd;
    logic     hit_tx_dest;
    logic     hit_tx_data;
    logic     hit_rx_data;
    logic     hit_status;
    logic     rx_empty;

    // A write wins if both enables are high.
    assign wr = bus_req.wen;
    assign rd = bus_req.ren && !bus_req.wen;

    assign hit_tx_dest = (bus_req.addr == REG_TX_DEST);
    assign hit_tx_data = (bus_req.addr == REG_TX_DATA);
    assign hit_rx_data = (bus_req.addr == REG_RX_DATA);
    assign hit_status  = (bus_req.addr == REG_STATUS);
    assign rx_empty    = (rx_count == '0);

    always_comb begin
        for (int b = 0; b < $bits(strobe_t); b++) begin
            tx_payload[8*b +: 8] = bus_req.strobe[b] ? bus_req.wdata[8*b +: 8] : 8'h00;
        end
    end

    // Held by the requester until the router takes it.
    assign inject      = wr && hit_tx_data;
    assign inject_flit = '{dest: tx_dest, src: NODE_ID, payload: tx_payload};
    assign rx_pop      = rd && hit_rx_data && !rx_empty;

    always_comb begin
        bus_rsp = '0;
        if (wr) begin
            if (hit_tx_data) begin
                bus_rsp.request_stall = !inject_ready;
            end else if (!hit_tx_dest) begin
                // Unmapped, or a read-only register.
                bus_rsp.error = 1'b1;
            end
        end else if (rd) begin
            if (hit_tx_dest) begin
                bus_rsp.rdata = data_t'(tx_dest);
            end else if (hit_rx_data) begin
                bus_rsp.rdata = rx_empty ? '0 : data_t'(rx_head.payload);
                bus_rsp.error = rx_empty;
            end else if (hit_status) begin
                bus_rsp.rdata = data_t'({rx_head.src, rx_count});
            end else if (!hit_tx_data) begin
                bus_rsp.error = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_dest <= '0;
        end else if (wr && hit_tx_dest && bus_req.strobe[0]) begin
            tx_dest <= bus_req.wdata[1:0];
        end
    end

endmodule

//--- hw/tile_router.sv
`timescale 1ns/1ps

module tile_router #(
    parameter chiplet_types_pkg::node_id_t NODE_ID = '0,
    parameter int BUFFER_SIZE = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           inject,
    input  chiplet_types_pkg::flit_t       inject_flit,
    output logic                           inject_ready,
    input  chiplet_types_pkg::link_fwd_t   link_in [chiplet_types_pkg::NUM_LINKS],
    output logic                           credit_out [chiplet_types_pkg::NUM_LINKS],
    output chiplet_types_pkg::link_fwd_t   link_out [chiplet_types_pkg::NUM_LINKS],
    input  logic                           credit_in [chiplet_types_pkg::NUM_LINKS],
    input  logic                           rx_pop,
    output chiplet_types_pkg::flit_t       rx_head,
    output chiplet_types_pkg::credit_cnt_t rx_count
);
    import chiplet_types_pkg::*;

    // Ports 0 and 1 are the links, port 2 is inject on the input side
    // and the local receive FIFO on the output side.
    typedef logic [1:0] port_t;

    localparam int    NUM_PORTS  = 3;
    localparam port_t PORT_LOCAL = 2'd2;

    flit_t                in_flit [NUM_PORTS];
    logic                 in_valid [NUM_PORTS];
    port_t                in_route [NUM_PORTS];
    logic                 in_empty [NUM_LINKS];
    logic                 link_pop [NUM_LINKS];
    logic                 out_ready [NUM_PORTS];
    logic [NUM_PORTS-1:0] gnt [NUM_PORTS];
    logic                 out_valid [NUM_PORTS];
    flit_t                out_flit [NUM_PORTS];
    port_t                rr_ptr [NUM_PORTS];
    credit_cnt_t          credit_cnt [NUM_LINKS];
    logic                 rx_full;

    // X first. The X link index equals this tile's Y bit.
    function automatic port_t route(input node_id_t dest);
        if (dest == NODE_ID) begin
            return PORT_LOCAL;
        end else if (dest[0] != NODE_ID[0]) begin
            return {1'b0, NODE_ID[1]};
        end
        return {1'b0, !NODE_ID[1]};
    endfunction

    ////////////////////
    // Link inputs and outputs.
    ////////////////////

    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
        flit_fifo #(
            .DEPTH(BUFFER_SIZE)
        ) i_in_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (link_in[l].valid),
            .push_flit(link_in[l].flit),
            .pop      (link_pop[l]),
            .head     (in_flit[l]),
            .empty    (in_empty[l]),
            .full     (),
            .count    ()
        );

        assign in_valid[l]  = !in_empty[l];
        assign link_pop[l]  = gnt[0][l] | gnt[1][l] | gnt[2][l];
        assign out_ready[l] = (credit_cnt[l] != '0);
        assign link_out[l]  = '{valid: out_valid[l], flit: out_flit[l]};

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                credit_out[l] <= 1'b0;
                credit_cnt[l] <= credit_cnt_t'(BUFFER_SIZE);
            end else begin
                credit_out[l] <= link_pop[l];
                case ({out_valid[l], credit_in[l]})
                    2'b10:   credit_cnt[l] <= credit_cnt[l] - 1'b1;
                    2'b01:   credit_cnt[l] <= credit_cnt[l] + 1'b1;
                    default: credit_cnt[l] <= credit_cnt[l];
                endcase
            end
        end
    end

    assign in_flit[PORT_LOCAL]   = inject_flit;
    assign in_valid[PORT_LOCAL]  = inject;
    assign out_ready[PORT_LOCAL] = !rx_full;
    assign inject_ready          = gnt[0][PORT_LOCAL] | gnt[1][PORT_LOCAL] | gnt[2][PORT_LOCAL];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_route[i] = route(in_flit[i].dest);
        end
    end

    ////////////////////
    // Round-robin arbitration, one grant per output.
    ////////////////////

    always_comb begin
        int idx;
        for (int o = 0; o < NUM_PORTS; o++) begin
            gnt[o] = '0;
            for (int k = 0; k < NUM_PORTS; k++) begin
                idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
                if (gnt[o] == '0 && out_ready[o] && in_valid[idx]
                        && in_route[idx] == port_t'(o)) begin
                    gnt[o][idx] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_valid[o] = |gnt[o];
            out_flit[o]  = in_flit[0];
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (gnt[o][i]) begin
                    out_flit[o] = in_flit[i];
                end
            end
        end
    end

    // The winner drops to lowest priority.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (gnt[o][i]) begin
                        rr_ptr[o] <= (i == NUM_PORTS - 1) ? '0 : port_t'(i + 1);
                    end
                end
            end
        end
    end

    flit_fifo #(
        .DEPTH(BUFFER_SIZE)
    ) i_rx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (out_valid[PORT_LOCAL]),
        .push_flit(out_flit[PORT_LOCAL]),
        .pop      (rx_pop),
        .head     (rx_head),
        .empty    (),
        .full     (rx_full),
        .count    (rx_count)
    );

endmodule

//--- hw/tile_wrapper.sv
`timescale 1ns/1ps

module tile_wrapper #(
    parameter int BUFFER_SIZE = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  chiplet_bus_pkg::bus_req_t bus_req [chiplet_types_pkg::NUM_TILES],
    output chiplet_bus_pkg::bus_rsp_t bus_rsp [chiplet_types_pkg::NUM_TILES]
);
    import chiplet_types_pkg::*;

    link_fwd_t tile_link_in    [NUM_TILES][NUM_LINKS];
    link_fwd_t tile_link_out   [NUM_TILES][NUM_LINKS];
    logic      tile_credit_in  [NUM_TILES][NUM_LINKS];
    logic      tile_credit_out [NUM_TILES][NUM_LINKS];

    tile #(.NODE_ID(2'd0), .BUFFER_SIZE(BUFFER_SIZE)) tile_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req[0]),
        .bus_rsp   (bus_rsp[0]),
        .link_in   (tile_link_in[0]),
        .credit_out(tile_credit_out[0]),
        .link_out  (tile_link_out[0]),
        .credit_in (tile_credit_in[0])
    );

    tile #(.NODE_ID(2'd1), .BUFFER_SIZE(BUFFER_SIZE)) tile_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req[1]),
        .bus_rsp   (bus_rsp[1]),
        .link_in   (tile_link_in[1]),
        .credit_out(tile_credit_out[1]),
        .link_out  (tile_link_out[1]),
        .credit_in (tile_credit_in[1])
    );

    tile #(.NODE_ID(2'd2), .BUFFER_SIZE(BUFFER_SIZE)) tile_2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req[2]),
        .bus_rsp   (bus_rsp[2]),
        .link_in   (tile_link_in[2]),
        .credit_out(tile_credit_out[2]),
        .link_out  (tile_link_out[2]),
        .credit_in (tile_credit_in[2])
    );

    tile #(.NODE_ID(2'd3), .BUFFER_SIZE(BUFFER_SIZE)) tile_3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req[3]),
        .bus_rsp   (bus_rsp[3]),
        .link_in   (tile_link_in[3]),
        .credit_out(tile_credit_out[3]),
        .link_out  (tile_link_out[3]),
        .credit_in (tile_credit_in[3])
    );

    ////////////////////
    // Square wiring. Credits return on the same pairing as flits.
    ////////////////////

    assign tile_link_in[0][0] = tile_link_out[1][0];
    assign tile_link_in[0][1] = tile_link_out[2][0];
    assign tile_link_in[1][0] = tile_link_out[0][0];
    assign tile_link_in[1][1] = tile_link_out[3][0];
    assign tile_link_in[2][0] = tile_link_out[0][1];
    assign tile_link_in[2][1] = tile_link_out[3][1];
    assign tile_link_in[3][0] = tile_link_out[1][1];
    assign tile_link_in[3][1] = tile_link_out[2][1];

    assign tile_credit_in[0][0] = tile_credit_out[1][0];
    assign tile_credit_in[0][1] = tile_credit_out[2][0];
    assign tile_credit_in[1][0] = tile_credit_out[0][0];
    assign tile_credit_in[1][1] = tile_credit_out[3][0];
    assign tile_credit_in[2][0] = tile_credit_out[0][1];
    assign tile_credit_in[2][1] = tile_credit_out[3][1];
    assign tile_credit_in[3][0] = tile_credit_out[1][1];
    assign tile_credit_in[3][1] = tile_credit_out[2][1];

endmodule
